/* hdl/cgra_pkg.sv */
package cgra_pkg;

   localparam int DATA_W    = 32;
   localparam int ADDR_W    = 8;
   localparam int MEM_DEPTH = 16;
   localparam int MEM_AW    = 4;
   localparam int MAX_STAGE = 4;

   // host address bits 7:6
   typedef enum logic [1:0] {
      REG_MEM   = 2'b00,
      REG_RUN   = 2'b01,
      REG_CONF  = 2'b10,
      REG_CLEAR = 2'b11
   } region_e;

   // word index inside the configuration region
   localparam logic [MEM_AW-1:0] CONF_ALU = 4'd0;
   localparam logic [MEM_AW-1:0] CONF_AGU = 4'd1;
   localparam logic [MEM_AW-1:0] CONF_ACC = 4'd2;

   typedef struct packed {
      logic              valid;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } host_req_t;

   // ring word between neighbouring stages
   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] data;
   } flow_t;

   // codes 5 to 7 are illegal
   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_XOR = 3'd3,
      OP_MAX = 3'd4
   } alu_op_e;

   typedef struct packed {
      logic [DATA_W-4:0] rsvd;
      alu_op_e           op;
   } alu_view_t;

   typedef struct packed {
      logic [DATA_W-14:0] rsvd;
      logic [4:0]         count;
      logic [3:0]         incr;
      logic [3:0]         start;
   } agu_view_t;

   typedef union packed {
      alu_view_t alu_view;
      agu_view_t agu_view;
   } conf_word_u;

   typedef struct packed {
      logic              we;
      region_e           region;
      logic [MEM_AW-1:0] idx;
      logic [DATA_W-1:0] wdata;
      logic              run_start;
      logic              conf_clear;
   } stage_cmd_t;

endpackage

/* hdl/host_decoder.sv */
`timescale 1ns/1ps

module host_decoder #(
   parameter int N_STAGE = 3
) (
   input  logic                 clk,
   input  logic                 rst,
   input  cgra_pkg::host_req_t  req,
   output logic                 ready,
   output cgra_pkg::stage_cmd_t cmd,
   output logic [N_STAGE-1:0]   stage_sel,
   output cgra_pkg::region_e    region
);

   logic [1:0] stage_idx;
   logic       bcast;
   logic       mem_rd;
   logic       seen_q;
   logic       seen2_q;
   logic       ready_nxt;
   logic       fire;

   assign region    = cgra_pkg::region_e'(req.addr[7:6]);
   assign stage_idx = req.addr[5:4];
   assign bcast     = (region == cgra_pkg::REG_RUN) || (region == cgra_pkg::REG_CLEAR);
   assign mem_rd    = (region == cgra_pkg::REG_MEM) && !req.we;

   // run and clear go to every stage
   for (genvar i = 0; i < N_STAGE; i++) begin : g_sel
      assign stage_sel[i] = req.valid && (bcast || stage_idx == 2'(i));
   end

   // memory reads wait for the registered read in the stage
   assign ready_nxt = req.valid && (mem_rd ? seen2_q : 1'b1);
   // first cycle of ready, once per transaction
   assign fire = ready_nxt && !ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         seen_q  <= 1'b0;
         seen2_q <= 1'b0;
         ready   <= 1'b0;
      end else begin
         seen_q  <= req.valid;
         seen2_q <= seen_q && req.valid;
         ready   <= ready_nxt;
      end
   end

   always_comb begin
      cmd.we         = req.we && fire;
      cmd.region     = region;
      cmd.idx        = req.addr[3:0];
      cmd.wdata      = req.wdata;
      cmd.run_start  = fire && req.we && (region == cgra_pkg::REG_RUN);
      cmd.conf_clear = fire && (region == cgra_pkg::REG_CLEAR);
   end

   // one stage at a time outside the broadcast regions
   a_sel_onehot : assert property (@(posedge clk) disable iff (rst)
      !bcast |-> $onehot0(stage_sel));

   // addresses past the last stage hit nothing
   a_sel_range : assert property (@(posedge clk) disable iff (rst)
      (!bcast && int'(stage_idx) >= N_STAGE) |-> (stage_sel == '0));

endmodule

/* hdl/stage_agu.sv */
`timescale 1ns/1ps

module stage_agu (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        start,
   input  cgra_pkg::conf_word_u        conf,
   output logic [cgra_pkg::MEM_AW-1:0] addr,
   output logic                        addr_valid,
   output logic                        busy
);

   logic [cgra_pkg::MEM_AW-1:0] addr_q;
   logic [4:0]                  left_q;
   logic [1:0]                  drain_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         addr_q  <= '0;
         left_q  <= '0;
         drain_q <= '0;
      end else if (start) begin
         addr_q  <= conf.agu_view.start;
         left_q  <= conf.agu_view.count;
         drain_q <= '0;
      end else if (left_q != '0) begin
         // wraps modulo 16 on its own
         addr_q <= addr_q + conf.agu_view.incr;
         left_q <= left_q - 5'd1;
         // last address, cover memory read and ring register
         if (left_q == 5'd1) begin
            drain_q <= 2'd2;
         end
      end else if (drain_q != '0) begin
         drain_q <= drain_q - 2'd1;
      end
   end

   assign addr       = addr_q;
   assign addr_valid = (left_q != '0);
   assign busy       = addr_valid || (drain_q != '0);

endmodule

/* hdl/stage_alu.sv */
`timescale 1ns/1ps

module stage_alu (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        clear,
   input  cgra_pkg::conf_word_u        conf,
   input  cgra_pkg::flow_t             own,
   input  cgra_pkg::flow_t             ring,
   output logic [cgra_pkg::DATA_W-1:0] acc
);

   logic [cgra_pkg::DATA_W-1:0] result;
   logic                        both;

   assign both = own.valid && ring.valid;

   always_comb begin
      case (conf.alu_view.op)
         cgra_pkg::OP_ADD: result = ring.data + own.data;
         cgra_pkg::OP_SUB: result = ring.data - own.data;
         cgra_pkg::OP_AND: result = ring.data & own.data;
         cgra_pkg::OP_XOR: result = ring.data ^ own.data;
         // unsigned compare
         cgra_pkg::OP_MAX: result = (ring.data > own.data) ? ring.data : own.data;
         default:          result = '0;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc <= '0;
      end else if (clear) begin
         acc <= '0;
      end else if (both) begin
         acc <= acc + result;
      end
   end

   // host config must hold a legal op while data flows
   a_legal_op : assert property (@(posedge clk) disable iff (rst)
      (own.valid || ring.valid) |-> (conf.alu_view.op inside {cgra_pkg::OP_ADD,
         cgra_pkg::OP_SUB, cgra_pkg::OP_AND, cgra_pkg::OP_XOR, cgra_pkg::OP_MAX}));

endmodule

/* hdl/cgra_stage.sv */
`timescale 1ns/1ps

module cgra_stage (
   input  logic                        clk,
   input  logic                        rst,
   input  cgra_pkg::stage_cmd_t        cmd,
   input  logic                        sel,
   input  cgra_pkg::flow_t             flow_in,
   output cgra_pkg::flow_t             flow_out,
   output logic [cgra_pkg::DATA_W-1:0] stage_rdata,
   output logic                        done
);

   logic [cgra_pkg::DATA_W-1:0] mem [cgra_pkg::MEM_DEPTH];
   cgra_pkg::conf_word_u        conf_alu;
   cgra_pkg::conf_word_u        conf_agu;
   cgra_pkg::flow_t             rd_q;
   logic [cgra_pkg::MEM_AW-1:0] agu_addr;
   logic [cgra_pkg::DATA_W-1:0] acc;
   logic                        agu_valid;
   logic                        busy;
   logic                        run_go;
   logic                        clr_go;
   logic                        mem_we;
   logic                        conf_we;

   assign run_go  = sel && cmd.run_start;
   assign clr_go  = sel && cmd.conf_clear;
   assign mem_we  = sel && cmd.we && (cmd.region == cgra_pkg::REG_MEM);
   assign conf_we = sel && cmd.we && (cmd.region == cgra_pkg::REG_CONF);
   assign done    = !busy && !run_go;

   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[cmd.idx] <= cmd.wdata;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         conf_alu <= '0;
         conf_agu <= '0;
      end else if (clr_go) begin
         conf_alu <= '0;
         conf_agu <= '0;
      end else if (conf_we) begin
         if (cmd.idx == cgra_pkg::CONF_ALU) conf_alu <= cmd.wdata;
         if (cmd.idx == cgra_pkg::CONF_AGU) conf_agu <= cmd.wdata;
      end
   end

   // host read port, one cycle late
   always_ff @(posedge clk) begin
      stage_rdata <= '0;
      if (cmd.region == cgra_pkg::REG_MEM) begin
         stage_rdata <= mem[cmd.idx];
      end else if (cmd.region == cgra_pkg::REG_CONF) begin
         case (cmd.idx)
            cgra_pkg::CONF_ALU: stage_rdata <= conf_alu;
            cgra_pkg::CONF_AGU: stage_rdata <= conf_agu;
            cgra_pkg::CONF_ACC: stage_rdata <= acc;
            default:            stage_rdata <= '0;
         endcase
      end
   end

   stage_agu u_agu (
      .clk        (clk),
      .rst        (rst),
      .start      (run_go),
      .conf       (conf_agu),
      .addr       (agu_addr),
      .addr_valid (agu_valid),
      .busy       (busy)
   );

   // run read, then a second register onto the ring
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_q     <= '0;
         flow_out <= '0;
      end else begin
         rd_q.valid <= agu_valid;
         rd_q.data  <= mem[agu_addr];
         flow_out   <= rd_q;
      end
   end

   // flow_out doubles as the delayed own word
   stage_alu u_alu (
      .clk   (clk),
      .rst   (rst),
      .clear (run_go || clr_go),
      .conf  (conf_alu),
      .own   (flow_out),
      .ring  (flow_in),
      .acc   (acc)
   );

   // host must not touch memory during a run
   a_no_wr_busy : assert property (@(posedge clk) disable iff (rst)
      busy |-> !mem_we);

endmodule

/* hdl/read_collector.sv */
`timescale 1ns/1ps

module read_collector #(
   parameter int N_STAGE = 3
) (
   input  logic [cgra_pkg::DATA_W-1:0] stage_rdata [N_STAGE],
   input  logic [N_STAGE-1:0]          done,
   input  logic [N_STAGE-1:0]          stage_sel,
   input  cgra_pkg::region_e           region,
   output logic [cgra_pkg::DATA_W-1:0] rdata
);

   logic all_done;

   // array is finished only when every stage is
   assign all_done = &done;

   always_comb begin
      rdata = '0;
      if (region == cgra_pkg::REG_RUN) begin
         rdata = {{(cgra_pkg::DATA_W - 1){1'b0}}, all_done};
      end else begin
         for (int i = 0; i < N_STAGE; i++) begin
            if (stage_sel[i]) begin
               rdata = stage_rdata[i];
            end
         end
      end
   end

endmodule

/* hdl/cgra_top.sv */
`timescale 1ns/1ps

module cgra_top #(
   parameter int N_STAGE = 3
) (
   input  logic                        clk,
   input  logic                        rst,
   input  cgra_pkg::host_req_t         req,
   output logic                        ready,
   output logic [cgra_pkg::DATA_W-1:0] rdata
);

   cgra_pkg::stage_cmd_t        cmd;
   cgra_pkg::region_e           region;
   logic [N_STAGE-1:0]          stage_sel;
   logic [N_STAGE-1:0]          done;
   cgra_pkg::flow_t             ring [N_STAGE];
   logic [cgra_pkg::DATA_W-1:0] stage_rdata [N_STAGE];

   // stage select is only two address bits wide
   if (N_STAGE < 2 || N_STAGE > cgra_pkg::MAX_STAGE) begin : g_bad_n_stage
      $error("N_STAGE out of range");
   end

   host_decoder #(.N_STAGE(N_STAGE)) u_decoder (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .ready     (ready),
      .cmd       (cmd),
      .stage_sel (stage_sel),
      .region    (region)
   );

   // stage i listens to stage i-1, stage 0 closes the ring
   for (genvar i = 0; i < N_STAGE; i++) begin : g_stage
      cgra_stage u_stage (
         .clk         (clk),
         .rst         (rst),
         .cmd         (cmd),
         .sel         (stage_sel[i]),
         .flow_in     (ring[(i + N_STAGE - 1) % N_STAGE]),
         .flow_out    (ring[i]),
         .stage_rdata (stage_rdata[i]),
         .done        (done[i])
      );
   end

   read_collector #(.N_STAGE(N_STAGE)) u_collector (
      .stage_rdata (stage_rdata),
      .done        (done),
      .stage_sel   (stage_sel),
      .region      (region),
      .rdata       (rdata)
   );

endmodule

/* bench/cgra_tb.sv */
`timescale 1ns/1ps

module cgra_tb;

   localparam int N_STAGE     = 3;
   localparam int READY_LIMIT = 12;
   localparam int POLL_LIMIT  = 40;

   logic                        clk = 1'b0;
   logic                        rst = 1'b1;
   cgra_pkg::host_req_t         req;
   logic                        ready;
   logic [cgra_pkg::DATA_W-1:0] rdata;

   // reference model of the array
   logic [31:0] mem_m   [N_STAGE][16];
   logic [31:0] conf_m  [N_STAGE][2];
   logic [3:0]  start_m [N_STAGE];
   logic [3:0]  incr_m  [N_STAGE];
   logic [4:0]  count_m [N_STAGE];
   logic [31:0] acc_m   [N_STAGE];

   logic        exp_on = 1'b0;
   logic [31:0] exp_rdata = '0;
   int          wait_cnt;
   int          ready_lat;
   logic        exp_ready;
   int          data_errs = 0;
   int          timing_errs = 0;
   int          timeout_errs = 0;

   cgra_top #(.N_STAGE(N_STAGE)) UUT (
      .clk   (clk),
      .rst   (rst),
      .req   (req),
      .ready (ready),
      .rdata (rdata)
   );

   always #50 clk = ~clk;

   // cycles that valid has been seen in the current transaction
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wait_cnt <= 0;
      end else if (!req.valid) begin
         wait_cnt <= 0;
      end else if (wait_cnt < 15) begin
         wait_cnt <= wait_cnt + 1;
      end
   end

   // memory reads take three cycles, everything else one
   assign ready_lat = (req.addr[7:6] == 2'b00 && !req.we) ? 3 : 1;
   assign exp_ready = (wait_cnt >= ready_lat);

   a_ready_rst : assert property (@(posedge clk) rst |=> !ready)
      else begin
         timing_errs++;
         $display("Fail ready after reset: got %h, expected %h", $sampled(ready), 1'b0);
      end

   a_ready_idle : assert property (@(posedge clk) disable iff (rst)
      !$past(req.valid) |-> !ready)
      else begin
         timing_errs++;
         $display("Fail ready while idle: got %h, expected %h", $sampled(ready), 1'b0);
      end

   a_ready_timing : assert property (@(posedge clk) disable iff (rst)
      req.valid |-> (ready == exp_ready))
      else begin
         timing_errs++;
         $display("Fail ready at addr %h: got %h, expected %h", $sampled(req.addr),
            $sampled(ready), $sampled(exp_ready));
      end

   a_rdata : assert property (@(posedge clk) disable iff (rst)
      (req.valid && ready && exp_on) |-> (rdata == exp_rdata))
      else begin
         data_errs++;
         $display("Fail rdata at addr %h: got %h, expected %h", $sampled(req.addr),
            $sampled(rdata), $sampled(exp_rdata));
      end

   function automatic logic [7:0] host_addr(input int region, input int stage, input int idx);
      return {2'(region), 2'(stage), 4'(idx)};
   endfunction

   // one ring step: previous stage word against own word
   function automatic logic [31:0] apply_op(input logic [2:0] op, input logic [31:0] r,
                                            input logic [31:0] o);
      case (op)
         3'd0: return r + o;
         3'd1: return r - o;
         3'd2: return r & o;
         3'd3: return r ^ o;
         3'd4: return (r > o) ? r : o;
         default: return '0;
      endcase
   endfunction

   task automatic host_access(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                              input logic check, input logic [31:0] expv, input int hold,
                              output logic [31:0] got);
      int n;
      @(posedge clk);
      req.valid <= 1'b1;
      req.we    <= we;
      req.addr  <= addr;
      req.wdata <= wdata;
      exp_on    <= check;
      exp_rdata <= expv;
      n   = 0;
      got = '0;
      do begin
         @(posedge clk);
         n++;
      end while (!ready && n < READY_LIMIT);
      if (!ready) begin
         timeout_errs++;
         $display("timeout: ready never rose for address %h", addr);
      end else begin
         got = rdata;
         // hold valid to see ready stay up
         repeat (hold) @(posedge clk);
      end
      req.valid <= 1'b0;
      exp_on    <= 1'b0;
   endtask

   task automatic write_word(input logic [7:0] addr, input logic [31:0] data, input int hold);
      logic [31:0] unused;
      host_access(1'b1, addr, data, 1'b0, '0, hold, unused);
   endtask

   task automatic expect_word(input logic [7:0] addr, input logic [31:0] expv, input int hold);
      logic [31:0] unused;
      host_access(1'b0, addr, '0, 1'b1, expv, hold, unused);
   endtask

   task automatic run_and_check(input logic [2:0] op);
      int          p;
      int          lim;
      int          polls;
      logic [31:0] own_w;
      logic [31:0] ring_w;
      logic [31:0] status;
      for (int s = 0; s < N_STAGE; s++) begin
         for (int w = 0; w < 16; w++) begin
            mem_m[s][w] = $urandom();
            write_word(host_addr(0, s, w), mem_m[s][w], 0);
         end
      end
      for (int s = 0; s < N_STAGE; s++) begin
         start_m[s] = 4'($urandom());
         incr_m[s]  = 4'($urandom());
         // stage 0 long enough that done is still low on the first poll
         count_m[s] = (s == 0) ? 5'(6 + $urandom() % 11) : 5'($urandom() % 17);
         write_word(host_addr(2, s, 0), {29'h0, op}, 0);
         write_word(host_addr(2, s, 1), {19'h0, count_m[s], incr_m[s], start_m[s]}, 0);
      end
      for (int s = 0; s < N_STAGE; s++) begin
         p        = (s + N_STAGE - 1) % N_STAGE;
         lim      = (count_m[s] < count_m[p]) ? count_m[s] : count_m[p];
         acc_m[s] = '0;
         for (int k = 0; k < lim; k++) begin
            own_w    = mem_m[s][(start_m[s] + k * incr_m[s]) % 16];
            ring_w   = mem_m[p][(start_m[p] + k * incr_m[p]) % 16];
            acc_m[s] = acc_m[s] + apply_op(op, ring_w, own_w);
         end
      end
      write_word(8'h40, '0, 0);
      expect_word(8'h40, 32'h0, 0);
      polls  = 0;
      status = '0;
      while (status[0] !== 1'b1 && polls < POLL_LIMIT) begin
         host_access(1'b0, 8'h40, '0, 1'b0, '0, 0, status);
         polls++;
      end
      if (status[0] !== 1'b1) begin
         timeout_errs++;
         $display("timeout: array never reported done for op %0d", op);
      end
      for (int s = 0; s < N_STAGE; s++) begin
         expect_word(host_addr(2, s, 2), acc_m[s], 0);
      end
   endtask

   initial begin
      req = '0;
      void'($urandom(32'h7dc3));
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      // memory write and read back, a few with valid held longer
      for (int s = 0; s < N_STAGE; s++) begin
         for (int w = 0; w < 16; w++) begin
            mem_m[s][w] = $urandom();
            write_word(host_addr(0, s, w), mem_m[s][w], (w == 5) ? 2 : 0);
         end
      end
      for (int s = 0; s < N_STAGE; s++) begin
         for (int w = 0; w < 16; w++) begin
            expect_word(host_addr(0, s, w), mem_m[s][w], (w == 3) ? 2 : 0);
         end
      end

      for (int s = 0; s < N_STAGE; s++) begin
         expect_word(host_addr(2, s, 2), 32'h0, 0);
      end
      for (int s = 0; s < N_STAGE; s++) begin
         conf_m[s][0] = $urandom();
         write_word(host_addr(2, s, 0), conf_m[s][0], 0);
         expect_word(host_addr(2, s, 0), conf_m[s][0], 1);
         conf_m[s][1] = $urandom();
         write_word(host_addr(2, s, 1), conf_m[s][1], 0);
         expect_word(host_addr(2, s, 1), conf_m[s][1], 0);
      end

      for (int op = 0; op < 5; op++) begin
         run_and_check(3'(op));
      end

      // global clear, then an empty run
      write_word(8'hC0, '0, 0);
      for (int s = 0; s < N_STAGE; s++) begin
         expect_word(host_addr(2, s, 0), 32'h0, 0);
         expect_word(host_addr(2, s, 1), 32'h0, 0);
         expect_word(host_addr(2, s, 2), 32'h0, 0);
      end
      write_word(8'h40, '0, 0);
      expect_word(8'h40, 32'h1, 0);
      for (int s = 0; s < N_STAGE; s++) begin
         expect_word(host_addr(2, s, 2), 32'h0, 0);
      end

      repeat (2) @(posedge clk);
      $display("errors: data %0d, timing %0d, timeout %0d", data_errs, timing_errs,
         timeout_errs);
      if (data_errs + timing_errs + timeout_errs == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
hdl/cgra_pkg.sv
hdl/host_decoder.sv
hdl/stage_agu.sv
hdl/stage_alu.sv
hdl/cgra_stage.sv
hdl/read_collector.sv
hdl/cgra_top.sv
bench/cgra_tb.sv
